/* design/mem_cfg_pkg.sv */
// memory config package: sizes of the storage and the conduit bus, plus read latency
`default_nettype none

package mem_cfg_pkg;

   // --------------------
   // bus lanes
   // --------------------
   // bits per byte lane
   localparam int SYMBOL_W = 8;
   // byte lanes per word
   localparam int NUM_SYMBOLS = 4;
   // full data word
   localparam int DATA_W = SYMBOL_W * NUM_SYMBOLS;

   // --------------------
   // addressing
   // --------------------
   // byte address as seen on the bus
   localparam int ADDR_W = 8;
   // low address bits picking a lane inside a word
   localparam int LANE_SEL_W = $clog2(NUM_SYMBOLS);
   localparam int WORD_ADDR_W = ADDR_W - LANE_SEL_W;
   // one word per word address
   localparam int NUM_WORDS = 2 ** WORD_ADDR_W;

   // cycles from a sampled read to data on the bus
   localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
// memory bus types package: vector types for addresses, data words and byte enables
`default_nettype none

package mem_bus_pkg;

   // --------------------
   // address types
   // --------------------
   // byte address from the conduit
   typedef logic [mem_cfg_pkg::ADDR_W-1:0] byte_addr_t;

   // index into the word storage, lane bits dropped
   typedef logic [mem_cfg_pkg::WORD_ADDR_W-1:0] word_addr_t;

   // --------------------
   // data types
   // --------------------
   // one storage word, also the width of the data bus
   typedef logic [mem_cfg_pkg::DATA_W-1:0] word_t;

   // one enable bit per byte lane
   // bit i covers data bits [i*SYMBOL_W +: SYMBOL_W]
   typedef logic [mem_cfg_pkg::NUM_SYMBOLS-1:0] byte_en_t;

   // note: all values are plain vectors, so slices and
   // bitwise ops work across types of the same width

endpackage

`default_nettype wire

/* design/bus_decode.sv */
// bus decode: qualifies strobes by chip select, forms the word index and the lane bit mask
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
   input  mem_bus_pkg::byte_addr_t address,
   input  mem_bus_pkg::byte_en_t   byte_enable,
   input  logic                    chip_select,
   input  logic                    read,
   input  logic                    write,
   output mem_bus_pkg::word_addr_t word_addr,
   output mem_bus_pkg::word_t      bit_mask,
   output logic                    read_req,
   output logic                    write_req
);

   // --------------------
   // strobe qualification
   // --------------------
   // nothing happens unless the chip is selected
   assign write_req = chip_select & write;

   // write wins when both strobes are up in one cycle,
   // so a read request only comes from a pure read
   assign read_req = chip_select & read & ~write;

   // --------------------
   // address conversion
   // --------------------
   // byte address to word index
   // lane select bits are ignored, the word is always accessed whole
   assign word_addr = address[mem_cfg_pkg::ADDR_W-1:mem_cfg_pkg::LANE_SEL_W];

   // --------------------
   // byte enable expansion
   // --------------------
   // each enable bit fans out across its lane
   always_comb begin
      for (int lane = 0; lane < mem_cfg_pkg::NUM_SYMBOLS; lane++) begin
         bit_mask[lane*mem_cfg_pkg::SYMBOL_W +: mem_cfg_pkg::SYMBOL_W] =
            {mem_cfg_pkg::SYMBOL_W{byte_enable[lane]}};
      end
   end

   // the same mask is used for write merge and for read masking,
   // so both sides of the bus agree on which lanes are live

endmodule

`default_nettype wire

/* design/mem_array.sv */
// memory array: word storage with reset clear, byte-masked write and combinational read
`timescale 1ns/1ps
`default_nettype none

module mem_array (
   input  logic                    clk,
   input  logic                    internal_reset,
   input  mem_bus_pkg::word_addr_t word_addr,
   input  mem_bus_pkg::word_t      bit_mask,
   input  logic                    write_req,
   input  mem_bus_pkg::word_t      data_in,
   output mem_bus_pkg::word_t      rd_word
);

   // --------------------
   // storage
   // --------------------
   // one entry per word address
   mem_bus_pkg::word_t mem_q [mem_cfg_pkg::NUM_WORDS];

   // merged word for the current write
   mem_bus_pkg::word_t wr_word;

   // --------------------
   // write merge
   // --------------------
   // old bits where the mask is low, new bits where it is high
   assign wr_word = (rd_word & ~bit_mask) | (data_in & bit_mask);

   // --------------------
   // storage update
   // --------------------
   // reset brings every word back to zero
   // writes land at the sampling edge
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int w = 0; w < mem_cfg_pkg::NUM_WORDS; w++) begin
            mem_q[w] <= '0;
         end
      end else if (write_req) begin
         mem_q[word_addr] <= wr_word;
      end
   end

   // --------------------
   // read port
   // --------------------
   // addressed word, no register
   // a read in the same cycle as a write still sees the old word,
   // the new value shows from the next cycle on
   assign rd_word = mem_q[word_addr];

   // Masking of the read data is left to the output side,
   // it happens there at issue time.

endmodule

`default_nettype wire

/* design/read_pipe.sv */
// read pipe: fixed-latency shift register carrying masked read data and the bus drive flag
`timescale 1ns/1ps
`default_nettype none

module read_pipe (
   input  logic               clk,
   input  logic               internal_reset,
   input  logic               read_req,
   input  logic               output_enable,
   input  mem_bus_pkg::word_t rd_word,
   input  mem_bus_pkg::word_t bit_mask,
   output mem_bus_pkg::word_t data_out,
   output logic               data_oe
);

   // --------------------
   // pipeline stages
   // --------------------
   // index 0 is loaded at issue, last index faces the bus
   logic               drive_q [mem_cfg_pkg::READ_LATENCY];
   mem_bus_pkg::word_t word_q  [mem_cfg_pkg::READ_LATENCY];

   // issue side values
   logic               drive_in;
   mem_bus_pkg::word_t word_in;

   // bus is only driven for a read with output enable up
   assign drive_in = read_req & output_enable;

   // disabled lanes read back as zero
   assign word_in = rd_word & bit_mask;

   // --------------------
   // shift register
   // --------------------
   // one new entry every cycle, so reads can go back to back
   always_ff @(posedge clk or posedge internal_reset) begin
      if (internal_reset) begin
         for (int s = 0; s < mem_cfg_pkg::READ_LATENCY; s++) begin
            drive_q[s] <= 1'b0;
            word_q[s]  <= '0;
         end
      end else begin
         drive_q[0] <= drive_in;
         word_q[0]  <= word_in;
         // move every entry one stage towards the bus
         for (int s = 1; s < mem_cfg_pkg::READ_LATENCY; s++) begin
            drive_q[s] <= drive_q[s-1];
            word_q[s]  <= word_q[s-1];
         end
      end
   end

   // --------------------
   // bus side
   // --------------------
   assign data_oe = drive_q[mem_cfg_pkg::READ_LATENCY-1];

   // zero when not driving, stands in for the released bus
   assign data_out = data_oe ? word_q[mem_cfg_pkg::READ_LATENCY-1] : '0;

endmodule

`default_nettype wire

/* design/ext_mem_model.sv */
// external memory model top: conduit-style one-port memory with fixed read latency
`timescale 1ns/1ps
`default_nettype none

module ext_mem_model (
   input  logic                    clk,
   input  logic                    internal_reset,
   input  mem_bus_pkg::byte_addr_t address,
   input  mem_bus_pkg::word_t      data_in,
   input  mem_bus_pkg::byte_en_t   byte_enable,
   input  logic                    chip_select,
   input  logic                    read,
   input  logic                    write,
   input  logic                    output_enable,
   output mem_bus_pkg::word_t      data_out,
   output logic                    data_oe
);

   // --------------------
   // internal nets
   // --------------------
   // decoded request
   mem_bus_pkg::word_addr_t word_addr;
   mem_bus_pkg::word_t      bit_mask;
   logic                    read_req;
   logic                    write_req;

   // word at the decoded address, before masking
   mem_bus_pkg::word_t      rd_word;

   // --------------------
   // input side
   // --------------------
   // strobe qualify, word index, lane mask
   bus_decode i_bus_decode (
      .address     (address),
      .byte_enable (byte_enable),
      .chip_select (chip_select),
      .read        (read),
      .write       (write),
      .word_addr   (word_addr),
      .bit_mask    (bit_mask),
      .read_req    (read_req),
      .write_req   (write_req)
   );

   // --------------------
   // storage
   // --------------------
   // writes at the edge, reads through
   mem_array i_mem_array (
      .clk            (clk),
      .internal_reset (internal_reset),
      .word_addr      (word_addr),
      .bit_mask       (bit_mask),
      .write_req      (write_req),
      .data_in        (data_in),
      .rd_word        (rd_word)
   );

   // --------------------
   // output side
   // --------------------
   // read latency and bus drive
   read_pipe i_read_pipe (
      .clk            (clk),
      .internal_reset (internal_reset),
      .read_req       (read_req),
      .output_enable  (output_enable),
      .rd_word        (rd_word),
      .bit_mask       (bit_mask),
      .data_out       (data_out),
      .data_oe        (data_oe)
   );

endmodule

`default_nettype wire

/* tests/ext_mem_model_tb.sv */
// testbench for the external memory model: directed tests checked against a reference word array
`timescale 1ns/1ps
`default_nettype none

module ext_mem_model_tb;

   localparam int LAT = mem_cfg_pkg::READ_LATENCY;
   // longest wait for read data, in cycles
   localparam int WAIT_LIMIT = 20;
   localparam int NUM_B2B = 16;

   logic                    clk;
   logic                    internal_reset;
   mem_bus_pkg::byte_addr_t address;
   mem_bus_pkg::word_t      data_in;
   mem_bus_pkg::byte_en_t   byte_enable;
   logic                    chip_select;
   logic                    read;
   logic                    write;
   logic                    output_enable;
   mem_bus_pkg::word_t      data_out;
   logic                    data_oe;

   // reference storage and expected bus values for pipelined reads
   mem_bus_pkg::word_t model [mem_cfg_pkg::NUM_WORDS];
   logic               exp_oe_q [$];
   mem_bus_pkg::word_t exp_word_q [$];
   int checks;
   int errors;
   int tests;

   ext_mem_model i_dut (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .data_in        (data_in),
      .byte_enable    (byte_enable),
      .chip_select    (chip_select),
      .read           (read),
      .write          (write),
      .output_enable  (output_enable),
      .data_out       (data_out),
      .data_oe        (data_oe)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------
   // reference helpers
   // --------------------
   // every data bit follows the enable of its lane
   function automatic mem_bus_pkg::word_t lane_mask(input mem_bus_pkg::byte_en_t be);
      mem_bus_pkg::word_t m;
      for (int b = 0; b < mem_cfg_pkg::DATA_W; b++) begin
         m[b] = be[b / mem_cfg_pkg::SYMBOL_W];
      end
      return m;
   endfunction

   // one word covers NUM_SYMBOLS byte addresses
   function automatic int word_index(input mem_bus_pkg::byte_addr_t a);
      return int'(a) / mem_cfg_pkg::NUM_SYMBOLS;
   endfunction

   // enabled lanes take the new byte, the others keep theirs
   task automatic model_write(input mem_bus_pkg::byte_addr_t a, input mem_bus_pkg::word_t d,
                              input mem_bus_pkg::byte_en_t be);
      int w;
      w = word_index(a);
      for (int l = 0; l < mem_cfg_pkg::NUM_SYMBOLS; l++) begin
         if (be[l]) begin
            model[w][l*mem_cfg_pkg::SYMBOL_W +: mem_cfg_pkg::SYMBOL_W] =
               d[l*mem_cfg_pkg::SYMBOL_W +: mem_cfg_pkg::SYMBOL_W];
         end
      end
   endtask

   task automatic check_word(input string sig, input mem_bus_pkg::word_t exp,
                             input mem_bus_pkg::word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %h, got %h", sig, exp, act);
      end
   endtask

   task automatic check_flag(input string sig, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %h, got %h", sig, exp, act);
      end
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      $display("test %s finished with %0d errors", name, errors - start);
   endtask

   // --------------------
   // bus drivers
   // --------------------
   task automatic drive_bus(input mem_bus_pkg::byte_addr_t a, input mem_bus_pkg::word_t d,
                            input mem_bus_pkg::byte_en_t be, input logic cs, input logic rd,
                            input logic wr, input logic oe);
      @(posedge clk);
      address       <= a;
      data_in       <= d;
      byte_enable   <= be;
      chip_select   <= cs;
      read          <= rd;
      write         <= wr;
      output_enable <= oe;
   endtask

   task automatic drive_idle();
      drive_bus('0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic write_word(input mem_bus_pkg::byte_addr_t a, input mem_bus_pkg::word_t d,
                             input mem_bus_pkg::byte_en_t be);
      drive_bus(a, d, be, 1'b1, 1'b0, 1'b1, 1'b0);
      drive_idle();
      model_write(a, d, be);
   endtask

   // single read, waits for data_oe and checks the latency
   task automatic read_word(input mem_bus_pkg::byte_addr_t a, input mem_bus_pkg::byte_en_t be);
      mem_bus_pkg::word_t exp;
      int waited;
      exp = model[word_index(a)] & lane_mask(be);
      drive_bus(a, '0, be, 1'b1, 1'b1, 1'b0, 1'b1);
      drive_idle();
      // first negedge falls in the cycle right after the read cycle
      waited = 1;
      @(negedge clk);
      while (!data_oe && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!data_oe) begin
         errors++;
         $display("read at address %h got no data within %0d cycles", a, WAIT_LIMIT);
      end else begin
         checks++;
         if (waited != LAT) begin
            errors++;
            $display("read data came %0d cycles after the read instead of %0d", waited, LAT);
         end
         check_word("data_out", exp, data_out);
         // the bus is driven for one cycle only
         @(negedge clk);
         check_flag("data_oe", 1'b0, data_oe);
      end
   endtask

   // bus must stay released through the whole read latency
   task automatic expect_quiet();
      for (int c = 0; c <= LAT + 1; c++) begin
         @(negedge clk);
         check_flag("data_oe", 1'b0, data_oe);
         check_word("data_out", '0, data_out);
      end
   endtask

   // --------------------
   // directed tests
   // --------------------
   task automatic reset_clear();
      int start;
      start = errors;
      for (int w = 0; w < mem_cfg_pkg::NUM_WORDS; w++) begin
         read_word(mem_bus_pkg::byte_addr_t'(w * mem_cfg_pkg::NUM_SYMBOLS), '1);
      end
      report_test("reset_clear", start);
   endtask

   task automatic full_write_read();
      int start;
      mem_bus_pkg::byte_addr_t a [8];
      start = errors;
      for (int i = 0; i < 8; i++) begin
         a[i] = mem_bus_pkg::byte_addr_t'($urandom);
         write_word(a[i], mem_bus_pkg::word_t'($urandom), '1);
      end
      for (int i = 0; i < 8; i++) begin
         read_word(a[i], '1);
      end
      report_test("full_write_read", start);
   endtask

   task automatic byte_masked_write();
      int start;
      mem_bus_pkg::byte_addr_t a;
      mem_bus_pkg::byte_en_t be;
      start = errors;
      for (int i = 0; i < 6; i++) begin
         a = mem_bus_pkg::byte_addr_t'($urandom);
         be = mem_bus_pkg::byte_en_t'($urandom);
         if (be == '1) begin
            be = 4'b0101;
         end
         // known word first, then a partial overwrite
         write_word(a, 32'h1122_3344 + i, '1);
         write_word(a, mem_bus_pkg::word_t'($urandom), be);
         read_word(a, '1);
      end
      report_test("byte_masked_write", start);
   endtask

   task automatic byte_masked_read();
      int start;
      mem_bus_pkg::byte_addr_t a;
      mem_bus_pkg::byte_en_t be;
      start = errors;
      for (int i = 0; i < 6; i++) begin
         a = mem_bus_pkg::byte_addr_t'($urandom);
         be = mem_bus_pkg::byte_en_t'($urandom);
         if (be == '1) begin
            be = 4'b1010;
         end
         write_word(a, mem_bus_pkg::word_t'($urandom), '1);
         read_word(a, be);
      end
      report_test("byte_masked_read", start);
   endtask

   task automatic no_drive_cases();
      int start;
      mem_bus_pkg::byte_addr_t a;
      mem_bus_pkg::word_t d;
      start = errors;
      a = mem_bus_pkg::byte_addr_t'($urandom);
      d = mem_bus_pkg::word_t'($urandom);
      write_word(a, mem_bus_pkg::word_t'($urandom), '1);
      // read without chip select
      drive_bus(a, '0, '1, 1'b0, 1'b1, 1'b0, 1'b1);
      drive_idle();
      expect_quiet();
      // read without output enable
      drive_bus(a, '0, '1, 1'b1, 1'b1, 1'b0, 1'b0);
      drive_idle();
      expect_quiet();
      // read and write together, only the write happens
      drive_bus(a, d, '1, 1'b1, 1'b1, 1'b1, 1'b1);
      drive_idle();
      model_write(a, d, '1);
      expect_quiet();
      // plain idle cycle
      drive_idle();
      expect_quiet();
      read_word(a, '1);
      report_test("no_drive_cases", start);
   endtask

   task automatic back_to_back_reads();
      int start;
      mem_bus_pkg::byte_addr_t a;
      mem_bus_pkg::byte_en_t be;
      start = errors;
      exp_oe_q.delete();
      exp_word_q.delete();
      for (int c = 0; c < NUM_B2B + LAT + 2; c++) begin
         if (c < NUM_B2B) begin
            a = mem_bus_pkg::byte_addr_t'($urandom);
            be = mem_bus_pkg::byte_en_t'($urandom);
            drive_bus(a, '0, be, 1'b1, 1'b1, 1'b0, 1'b1);
            exp_oe_q.push_back(1'b1);
            exp_word_q.push_back(model[word_index(a)] & lane_mask(be));
         end else begin
            drive_idle();
            exp_oe_q.push_back(1'b0);
            exp_word_q.push_back('0);
         end
         @(negedge clk);
         // the oldest entry reaches the bus LAT cycles after it was driven
         if (exp_oe_q.size() > LAT) begin
            check_flag("data_oe", exp_oe_q.pop_front(), data_oe);
            check_word("data_out", exp_word_q.pop_front(), data_out);
         end
      end
      report_test("back_to_back_reads", start);
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      internal_reset = 1'b1;
      address        = '0;
      data_in        = '0;
      byte_enable    = '0;
      chip_select    = 1'b0;
      read           = 1'b0;
      write          = 1'b0;
      output_enable  = 1'b0;
      checks = 0;
      errors = 0;
      tests  = 0;
      for (int w = 0; w < mem_cfg_pkg::NUM_WORDS; w++) begin
         model[w] = '0;
      end
      void'($urandom(63910));
      repeat (8) @(posedge clk);
      internal_reset <= 1'b0;
      reset_clear();
      full_write_read();
      byte_masked_write();
      byte_masked_read();
      no_drive_cases();
      back_to_back_reads();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
design/mem_cfg_pkg.sv
design/mem_bus_pkg.sv
design/bus_decode.sv
design/mem_array.sv
design/read_pipe.sv
design/ext_mem_model.sv
tests/ext_mem_model_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for failures
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module ext_mem_model_tb \
   -f all.f -o ext_mem_model_sim \
   && ./obj_dir/ext_mem_model_sim > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation passed"
exit 0
